/* design/spart_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// SPART shared definitions
// Byte, divisor and queue-level widths, register map and reset divisor
////////////////////////////////////////////////////////////////////////////
package spart_pkg;

    // Widths that carry a meaning
    typedef logic [7:0]  data_t;       // One bus or serial byte
    typedef logic [12:0] baud_div_t;   // Clock cycles per serial bit
    typedef logic [3:0]  queue_cnt_t;  // Fill level or free space, depth <= 15
    typedef logic [1:0]  reg_addr_t;   // Register address

    ////////////////////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////////////////////
    localparam reg_addr_t ADDR_DATA   = 2'd0;  // W push TX queue, R pop RX queue
    localparam reg_addr_t ADDR_STATUS = 2'd1;  // {tx free, rx stored}
    localparam reg_addr_t ADDR_DIV_LO = 2'd2;  // Divisor bits 7:0
    localparam reg_addr_t ADDR_DIV_HI = 2'd3;  // Divisor bits 12:8

    // 115200 baud at 50 MHz
    localparam baud_div_t BAUD_DIV_RESET = 13'd434;

endpackage

/* design/circular_queue.sv */
////////////////////////////////////////////////////////////////////////////
// Circular byte queue
// DEPTH entries, wrapping read and write pointers, registered fill level
// and free space. Push when full and pop when empty are ignored.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module circular_queue #(
    parameter int DEPTH = 8              // 2 to 15 entries
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  spart_pkg::data_t        data_in,
    input  logic                    add,        // Push strobe
    input  logic                    remove,     // Pop strobe
    output spart_pkg::data_t        data_out,   // Head entry
    output logic                    q_full,
    output logic                    q_empty,
    output spart_pkg::queue_cnt_t   count,      // Entries stored
    output spart_pkg::queue_cnt_t   remaining   // Entries free
);

    import spart_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    data_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_add;
    logic             do_remove;

    // Qualified strobes
    assign do_add    = add && !q_full;
    assign do_remove = remove && !q_empty;

    assign q_full   = (count == queue_cnt_t'(DEPTH));
    assign q_empty  = (count == '0);
    assign data_out = mem[rd_ptr];

    // Storage, no reset on payload
    always_ff @(posedge clk) begin
        if (do_add)
            mem[wr_ptr] <= data_in;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and levels
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            remaining <= queue_cnt_t'(DEPTH);    // All free
        end else begin
            if (do_add)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_remove)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_add, do_remove})
                2'b10: begin
                    count     <= count + 1'b1;
                    remaining <= remaining - 1'b1;
                end
                2'b01: begin
                    count     <= count - 1'b1;
                    remaining <= remaining + 1'b1;
                end
                default: ;                       // Both or neither, level holds
            endcase
        end
    end

endmodule

/* design/uart_tx.sv */
////////////////////////////////////////////////////////////////////////////
// UART transmitter
// Pulls bytes from the TX queue and shifts out 8N1 frames, LSB first,
// each bit lasting baud_div clock cycles
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module uart_tx (
    input  logic                  clk,
    input  logic                  rst_n,
    input  spart_pkg::baud_div_t  baud_div,   // Cycles per bit
    input  spart_pkg::data_t      tx_head,    // Queue head byte
    input  logic                  tx_empty,
    output logic                  tx_pop,     // One-cycle pop of the head
    output logic                  tx_line
);

    import spart_pkg::*;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    tx_state_t  state;
    baud_div_t  bit_cnt;        // Cycles left in current bit
    logic [2:0] bit_idx;        // Data bit being sent
    data_t      shift_reg;      // Latched byte, shifts right
    logic       bit_done;

    assign bit_done = (bit_cnt == '0);

    // Pop as soon as idle with data waiting
    assign tx_pop = (state == TX_IDLE) && !tx_empty;

    // Line level per state
    always_comb begin
        case (state)
            TX_START: tx_line = 1'b0;
            TX_DATA:  tx_line = shift_reg[0];
            default:  tx_line = 1'b1;          // Idle and stop are mark
        endcase
    end

    // Payload latch, no reset
    always_ff @(posedge clk) begin
        if (tx_pop)
            shift_reg <= tx_head;
        else if (state == TX_DATA && bit_done)
            shift_reg <= {1'b0, shift_reg[7:1]};
    end

    ////////////////////////////////////////////////////////////////////////////
    // Frame FSM and bit timer
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= TX_IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
        end else begin
            if (state != TX_IDLE && !bit_done)
                bit_cnt <= bit_cnt - 1'b1;
            case (state)
                TX_IDLE: if (tx_pop) begin
                    state   <= TX_START;
                    bit_cnt <= baud_div - baud_div_t'(1);
                end
                TX_START: if (bit_done) begin
                    state   <= TX_DATA;
                    bit_idx <= '0;
                    bit_cnt <= baud_div - baud_div_t'(1);
                end
                TX_DATA: if (bit_done) begin
                    bit_cnt <= baud_div - baud_div_t'(1);
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7)
                        state <= TX_STOP;       // Last data bit sent
                end
                TX_STOP: if (bit_done)
                    state <= TX_IDLE;           // Next pop one cycle later
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

/* design/uart_rx.sv */
////////////////////////////////////////////////////////////////////////////
// UART receiver
// Synchronises RX, finds the start edge, samples each bit mid-bit and
// emits the byte with a one-cycle valid when the stop bit is high
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module uart_rx (
    input  logic                  clk,
    input  logic                  rst_n,
    input  spart_pkg::baud_div_t  baud_div,   // Cycles per bit
    input  logic                  rx_line,
    output logic                  rx_valid,   // One-cycle byte strobe
    output spart_pkg::data_t      rx_byte
);

    import spart_pkg::*;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t  state;
    logic       rx_meta;        // First sync flop
    logic       rx_sync;        // Second sync flop
    logic       rx_prev;        // For falling edge
    baud_div_t  bit_cnt;        // Cycles to next sample
    logic [2:0] bit_idx;
    logic       sample;
    logic       start_edge;

    assign sample     = (bit_cnt == '0);
    assign start_edge = rx_prev && !rx_sync;

    // Two-flop synchroniser, line idles high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_line;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // Data bits arrive LSB first, shift in from the top
    always_ff @(posedge clk) begin
        if (state == RX_DATA && sample)
            rx_byte <= {rx_sync, rx_byte[7:1]};
    end

    ////////////////////////////////////////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (state != RX_IDLE && !sample)
                bit_cnt <= bit_cnt - 1'b1;
            case (state)
                RX_IDLE: if (start_edge) begin
                    state   <= RX_START;
                    bit_cnt <= (baud_div >> 1) - baud_div_t'(1);  // Half bit
                end
                RX_START: if (sample) begin
                    if (!rx_sync) begin          // Start still low
                        state   <= RX_DATA;
                        bit_idx <= '0;
                        bit_cnt <= baud_div - baud_div_t'(1);
                    end else begin
                        state <= RX_IDLE;        // Glitch, false start
                    end
                end
                RX_DATA: if (sample) begin
                    bit_cnt <= baud_div - baud_div_t'(1);
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7)
                        state <= RX_STOP;
                end
                RX_STOP: if (sample) begin
                    rx_valid <= rx_sync;         // Bad stop bit drops frame
                    state    <= RX_IDLE;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

/* design/spart.sv */
////////////////////////////////////////////////////////////////////////////
// SPART top level
// Processor bus decode for four byte registers, 13-bit baud divisor,
// tristate data bus, TX and RX queues and the UART pair
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module spart #(
    parameter int QUEUE_DEPTH = 8             // 2 to 15, both queues
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  iocs_n,     // Chip select, active low
    input  logic                  iorw_n,     // High read, low write
    input  spart_pkg::reg_addr_t  ioaddr,
    inout  wire spart_pkg::data_t databus,    // Bidirectional data bus
    output logic                  tx_q_full,
    output logic                  rx_q_empty,
    output logic                  TX,
    input  logic                  RX
);

    import spart_pkg::*;

    logic       bus_rd;
    logic       bus_wr;
    logic       tx_push;
    logic       rx_pop;
    data_t      rd_data;        // Read mux output
    baud_div_t  baud_div;

    // TX queue side
    data_t      tx_head;
    logic       tx_q_empty;
    logic       tx_pop;
    queue_cnt_t tx_free;

    // RX queue side
    data_t      rx_head;
    logic       rx_valid;
    data_t      rx_byte;
    queue_cnt_t rx_stored;

    ////////////////////////////////////////////////////////////////////////////
    // Bus decode
    ////////////////////////////////////////////////////////////////////////////
    assign bus_rd  = !iocs_n && iorw_n;
    assign bus_wr  = !iocs_n && !iorw_n;
    assign tx_push = bus_wr && (ioaddr == ADDR_DATA);   // Lost when full
    assign rx_pop  = bus_rd && (ioaddr == ADDR_DATA);   // Ignored when empty

    always_comb begin
        case (ioaddr)
            ADDR_DATA:   rd_data = rx_q_empty ? '0 : rx_head;
            ADDR_STATUS: rd_data = {tx_free, rx_stored};
            ADDR_DIV_LO: rd_data = baud_div[7:0];
            default:     rd_data = {3'b000, baud_div[12:8]};
        endcase
    end

    // Drive only while the processor reads
    assign databus = bus_rd ? rd_data : 'z;

    // Divisor bytes load at the next edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            baud_div <= BAUD_DIV_RESET;
        else if (bus_wr && ioaddr == ADDR_DIV_LO)
            baud_div[7:0] <= databus;
        else if (bus_wr && ioaddr == ADDR_DIV_HI)
            baud_div[12:8] <= databus[4:0];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Queues and UART
    ////////////////////////////////////////////////////////////////////////////
    circular_queue #(.DEPTH(QUEUE_DEPTH)) i_tx_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .data_in   (databus),
        .add       (tx_push),
        .remove    (tx_pop),
        .data_out  (tx_head),
        .q_full    (tx_q_full),
        .q_empty   (tx_q_empty),
        .count     (),
        .remaining (tx_free)
    );

    circular_queue #(.DEPTH(QUEUE_DEPTH)) i_rx_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .data_in   (rx_byte),
        .add       (rx_valid),          // Dropped when full
        .remove    (rx_pop),
        .data_out  (rx_head),
        .q_full    (),
        .q_empty   (rx_q_empty),
        .count     (rx_stored),
        .remaining ()
    );

    uart_tx i_uart_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .baud_div (baud_div),
        .tx_head  (tx_head),
        .tx_empty (tx_q_empty),
        .tx_pop   (tx_pop),
        .tx_line  (TX)
    );

    uart_rx i_uart_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .baud_div (baud_div),
        .rx_line  (RX),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte)
    );

endmodule

/* testbench/tb_spart.sv */
////////////////////////////////////////////////////////////////////////////
// SPART testbench
// Table-driven processor bus test with TX looped back to RX. Expected
// values come from a reference model of both queues and the divisor
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_spart;

    import spart_pkg::*;

    localparam int QUEUE_DEPTH = 8;
    localparam int MAX_STEPS   = 128;

    // Step kinds
    localparam int OP_WRITE   = 0;
    localparam int OP_READ    = 1;
    localparam int OP_WAIT    = 2;
    localparam int OP_WAIT_RX = 3;
    localparam int OP_FLAGS   = 4;

    logic      clk;
    logic      rst_n;
    logic      iocs_n;
    logic      iorw_n;
    reg_addr_t ioaddr;
    data_t     bus_drv;         // Testbench side of the data bus
    logic      bus_en;          // High during writes
    wire [7:0] databus;
    logic      tx_q_full;
    logic      rx_q_empty;
    wire       serial_line;     // TX looped back to RX

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table and reference model
    ////////////////////////////////////////////////////////////////////////////
    string     step_name  [MAX_STEPS];
    int        step_op    [MAX_STEPS];
    reg_addr_t step_addr  [MAX_STEPS];
    data_t     step_wdata [MAX_STEPS];
    data_t     step_exp   [MAX_STEPS];
    int        step_wait  [MAX_STEPS];
    int        n_steps;

    data_t     line_q[$];       // Accepted and not yet received
    data_t     rx_model[$];     // Bytes stored in the RX queue
    baud_div_t div_model;
    int        max_div;         // Slowest divisor in the table
    int        wait_total;      // Sum of fixed waits

    integer    seed;
    int        cycle_count = 0;
    int        cycle_limit = 1000000;

    assign databus = bus_en ? bus_drv : 8'hzz;

    spart #(.QUEUE_DEPTH(QUEUE_DEPTH)) DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .iocs_n     (iocs_n),
        .iorw_n     (iorw_n),
        .ioaddr     (ioaddr),
        .databus    (databus),
        .tx_q_full  (tx_q_full),
        .rx_q_empty (rx_q_empty),
        .TX         (serial_line),
        .RX         (serial_line)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;      // 20 ns period

    // Run limit
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, the tests did not complete", cycle_count);
            $display("Simulation failed");
            $fatal(1, "Stopped on timeout");
        end
    end

    task automatic check_value(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected 8'h%02h, actual 8'h%02h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic append_step(input string name, input int op, input reg_addr_t addr,
                               input data_t wdata, input data_t expected, input int cycles);
        step_name[n_steps]  = name;
        step_op[n_steps]    = op;
        step_addr[n_steps]  = addr;
        step_wdata[n_steps] = wdata;
        step_exp[n_steps]   = expected;
        step_wait[n_steps]  = cycles;
        n_steps = n_steps + 1;
    endtask

    // Bytes waiting in the TX queue while the head of line_q is in the shifter
    function automatic int tx_held();
        return (line_q.size() > 0) ? line_q.size() - 1 : 0;
    endfunction

    task automatic deliver_byte();
        data_t b;
        if (line_q.size() > 0) begin
            b = line_q.pop_front();
            if (rx_model.size() < QUEUE_DEPTH)
                rx_model.push_back(b);  // Full RX queue drops it
        end
    endtask

    task automatic write_step(input string name, input reg_addr_t addr, input data_t data);
        case (addr)
            ADDR_DATA: begin
                if (tx_held() < QUEUE_DEPTH)
                    line_q.push_back(data);  // Otherwise lost
            end
            ADDR_DIV_LO: div_model[7:0] = data;
            ADDR_DIV_HI: div_model[12:8] = data[4:0];
            default: ;
        endcase
        if (int'(div_model) > max_div)
            max_div = div_model;
        append_step(name, OP_WRITE, addr, data, 8'h00, 0);
    endtask

    task automatic read_step(input string name, input reg_addr_t addr);
        data_t expected;
        case (addr)
            ADDR_DATA: begin
                if (rx_model.size() > 0)
                    expected = rx_model.pop_front();
                else
                    expected = 8'h00;      // Empty read
            end
            ADDR_STATUS: begin
                expected[7:4] = 4'(QUEUE_DEPTH - tx_held());
                expected[3:0] = 4'(rx_model.size());
            end
            ADDR_DIV_LO: expected = div_model[7:0];
            default:     expected = {3'b000, div_model[12:8]};
        endcase
        append_step(name, OP_READ, addr, 8'h00, expected, 0);
    endtask

    task automatic delay_step(input string name, input int cycles, input logic deliver_all);
        if (deliver_all) begin
            while (line_q.size() > 0)
                deliver_byte();
        end
        wait_total = wait_total + cycles;
        append_step(name, OP_WAIT, ADDR_DATA, 8'h00, 8'h00, cycles);
    endtask

    task automatic rx_wait_step(input string name);
        deliver_byte();
        append_step(name, OP_WAIT_RX, ADDR_DATA, 8'h00, 8'h00, 0);
    endtask

    // Flags byte is {tx_q_full, rx_q_empty, TX}
    task automatic flags_step(input string name, input logic tx_level);
        data_t expected;
        expected = {5'b00000, tx_held() >= QUEUE_DEPTH, rx_model.size() == 0, tx_level};
        append_step(name, OP_FLAGS, ADDR_DATA, 8'h00, expected, 0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////
    task automatic build_table();
        data_t b;
        read_step("reset divisor low", ADDR_DIV_LO);
        read_step("reset divisor high", ADDR_DIV_HI);
        read_step("reset status", ADDR_STATUS);
        flags_step("reset flags", 1'b1);
        // Divisor readback
        write_step("divisor low 8", ADDR_DIV_LO, 8'd8);
        write_step("divisor high 0", ADDR_DIV_HI, 8'd0);
        read_step("divisor low readback", ADDR_DIV_LO);
        read_step("divisor high readback", ADDR_DIV_HI);
        read_step("status after divisor", ADDR_STATUS);
        // Loopback order
        for (int i = 0; i < 4; i++) begin
            b = data_t'($random(seed));
            write_step("loopback write", ADDR_DATA, b);
        end
        for (int i = 0; i < 4; i++) begin
            rx_wait_step("loopback arrival");
            read_step("loopback read", ADDR_DATA);
        end
        flags_step("loopback flags", 1'b1);
        read_step("loopback status", ADDR_STATUS);
        // TX queue fill at divisor 200
        write_step("fill divisor low", ADDR_DIV_LO, 8'd200);
        write_step("fill divisor high", ADDR_DIV_HI, 8'd0);
        b = data_t'($random(seed));
        write_step("fill first write", ADDR_DATA, b);
        delay_step("transmitter takes first byte", 5, 1'b0);
        for (int i = 0; i < 8; i++) begin
            b = data_t'($random(seed));
            write_step("fill write", ADDR_DATA, b);
        end
        flags_step("fill flags", 1'b0);        // First byte still in start bit
        read_step("fill status", ADDR_STATUS);
        b = data_t'($random(seed));
        write_step("write to full queue", ADDR_DATA, b);
        read_step("status after lost write", ADDR_STATUS);
        for (int i = 0; i < 9; i++) begin
            rx_wait_step("fill arrival");
            read_step("fill read", ADDR_DATA);
        end
        // RX overflow back at divisor 8
        write_step("overflow divisor low", ADDR_DIV_LO, 8'd8);
        for (int i = 0; i < 5; i++) begin
            b = data_t'($random(seed));
            write_step("overflow write", ADDR_DATA, b);
        end
        // Stop bit of the last fill frame may still be on the line
        delay_step("overflow first five sent", 8 * 10 * int'(div_model), 1'b1);
        for (int i = 0; i < 5; i++) begin
            b = data_t'($random(seed));
            write_step("overflow write", ADDR_DATA, b);
        end
        delay_step("overflow all sent", 12 * 10 * int'(div_model), 1'b1);
        read_step("overflow status", ADDR_STATUS);
        flags_step("overflow flags", 1'b1);
        for (int i = 0; i < 9; i++)
            read_step("overflow read", ADDR_DATA);  // Ninth one is empty
        flags_step("flags after empty read", 1'b1);
        read_step("final status", ADDR_STATUS);
    endtask

    // One table entry starting on a falling edge
    task automatic run_step(input int i);
        @(negedge clk);
        iocs_n = 1'b1;
        iorw_n = 1'b1;
        bus_en = 1'b0;
        case (step_op[i])
            OP_WRITE: begin
                iocs_n  = 1'b0;
                iorw_n  = 1'b0;
                ioaddr  = step_addr[i];
                bus_drv = step_wdata[i];
                bus_en  = 1'b1;
            end
            OP_READ: begin
                iocs_n = 1'b0;
                ioaddr = step_addr[i];
                #5;                         // Bus settled by mid low phase
                check_value(step_name[i], step_exp[i], databus);
            end
            OP_WAIT:    repeat (step_wait[i]) @(negedge clk);
            OP_WAIT_RX: while (rx_q_empty) @(negedge clk);
            OP_FLAGS: begin
                check_value(step_name[i], step_exp[i],
                            {5'b00000, tx_q_full, rx_q_empty, serial_line});
            end
            default: begin
                $display("Step %0d has an unknown kind %0d", i, step_op[i]);
                $display("Simulation failed");
                $fatal(1, "Bad stimulus table");
            end
        endcase
    endtask

    initial begin
        rst_n   = 1'b0;
        iocs_n  = 1'b1;
        iorw_n  = 1'b1;
        ioaddr  = ADDR_DATA;
        bus_drv = 8'h00;
        bus_en  = 1'b0;
        seed       = 32'h7807;
        n_steps    = 0;
        wait_total = 0;
        div_model  = 13'd434;       // Reset divisor for 115200 baud at 50 MHz
        max_div    = int'(div_model);
        build_table();
        // Fixed waits plus 20 frames at the slowest divisor, access cycles and margin
        cycle_limit = wait_total + 20 * 10 * max_div + 20 * n_steps + 1000;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < n_steps; i++)
            run_step(i);
        @(negedge clk);
        iocs_n = 1'b1;
        bus_en = 1'b0;
        $display("Simulation passed");
        $finish;
    end

endmodule

/* sources.f */
design/spart_pkg.sv
design/circular_queue.sv
design/uart_tx.sv
design/uart_rx.sv
design/spart.sv
testbench/tb_spart.sv
